/* logic/stq_pkg.sv */
package stq_pkg;

  // ==========================================================================
  // Queue geometry
  // ==========================================================================
  parameter int STQ_SIZE = 8;   // Default entry count
  parameter int PADDR_W  = 32;
  parameter int DATA_W   = 64;  // One doubleword
  parameter int DATA_B_W = 8;   // Bytes per doubleword

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_DW
  } size_t;

  typedef enum logic [1:0] {
    STQ_EMPTY,
    STQ_WAIT,    // Address or data still missing
    STQ_READY,
    STQ_COMMIT
  } stq_state_t;

  // Byte mask of an access at offset zero
  function automatic logic [DATA_B_W-1:0] base_strb(size_t size);
    case (size)
      SIZE_B:  return 'h01;
      SIZE_H:  return 'h03;
      SIZE_W:  return 'h0f;
      default: return 'hff;
    endcase
  endfunction

endpackage

/* logic/stq_alloc.sv */
`timescale 1ns/1ps

module stq_alloc #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_disp_valid,
  input  logic                i_commit,
  input  logic                i_drain_fire,

  output logic [IDX_W-1:0]    o_disp_index,
  output logic [STQ_SIZE-1:0] o_alloc_oh,
  output logic [STQ_SIZE-1:0] o_commit_oh,
  output logic                o_credit_return
);

  logic [IDX_W-1:0] r_alloc_ptr;
  logic [IDX_W-1:0] r_commit_ptr;

  // Index goes out in the dispatch cycle itself
  assign o_disp_index = r_alloc_ptr;

  assign o_alloc_oh  = {{(STQ_SIZE-1){1'b0}}, i_disp_valid} << r_alloc_ptr;
  assign o_commit_oh = {{(STQ_SIZE-1){1'b0}}, i_commit} << r_commit_ptr;

  // ==========================================================================
  // Pointers wrap on their own, size is a power of two
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_ptr  <= '0;
      r_commit_ptr <= '0;
    end else begin
      if (i_disp_valid) begin
        r_alloc_ptr <= r_alloc_ptr + IDX_W'(1);
      end
      if (i_commit) begin
        r_commit_ptr <= r_commit_ptr + IDX_W'(1);
      end
    end
  end

  // One credit per drained entry, a cycle after the transfer
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_credit_return <= 1'b0;
    end else begin
      o_credit_return <= i_drain_fire;
    end
  end

endmodule

/* logic/stq_entries.sv */
`timescale 1ns/1ps

module stq_entries #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic [STQ_SIZE-1:0]           i_alloc_oh,
  input  logic [STQ_SIZE-1:0]           i_commit_oh,

  input  logic                          i_addr_valid,
  input  logic [IDX_W-1:0]              i_addr_index,
  input  logic [stq_pkg::PADDR_W-1:0]   i_addr_paddr,
  input  stq_pkg::size_t                i_addr_size,

  input  logic                          i_data_valid,
  input  logic [IDX_W-1:0]              i_data_index,
  input  logic [stq_pkg::DATA_W-1:0]    i_data,

  input  logic [STQ_SIZE-1:0]           i_free_oh,

  output stq_pkg::stq_state_t           o_state [STQ_SIZE],
  output logic [stq_pkg::PADDR_W-1:0]   o_paddr [STQ_SIZE],
  output stq_pkg::size_t                o_size  [STQ_SIZE],
  output logic [stq_pkg::DATA_W-1:0]    o_data  [STQ_SIZE]
);

  for (genvar s = 0; s < STQ_SIZE; s++) begin : g_entry
    stq_pkg::stq_state_t          r_state;
    logic                         r_addr_vld;
    logic                         r_data_vld;
    logic [stq_pkg::PADDR_W-1:0]  r_paddr;
    stq_pkg::size_t               r_size;
    logic [stq_pkg::DATA_W-1:0]   r_data;
    logic                         w_addr_hit;
    logic                         w_data_hit;
    logic                         w_addr_done;
    logic                         w_data_done;

    assign w_addr_hit  = i_addr_valid & (i_addr_index == IDX_W'(s));
    assign w_data_hit  = i_data_valid & (i_data_index == IDX_W'(s));
    assign w_addr_done = r_addr_vld | w_addr_hit;  // Counts an update arriving now
    assign w_data_done = r_data_vld | w_data_hit;

    // ========================================================================
    // Entry FSM
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state    <= stq_pkg::STQ_EMPTY;
        r_addr_vld <= 1'b0;
        r_data_vld <= 1'b0;
      end else begin
        case (r_state)
          stq_pkg::STQ_EMPTY: begin
            if (i_alloc_oh[s]) begin
              r_state    <= stq_pkg::STQ_WAIT;
              r_addr_vld <= 1'b0;
              r_data_vld <= 1'b0;
            end
          end
          stq_pkg::STQ_WAIT: begin
            r_addr_vld <= w_addr_done;
            r_data_vld <= w_data_done;
            if (w_addr_done & w_data_done) begin
              r_state <= stq_pkg::STQ_READY;
            end
          end
          stq_pkg::STQ_READY: begin
            if (i_commit_oh[s]) r_state <= stq_pkg::STQ_COMMIT;
          end
          default: begin
            if (i_free_oh[s]) r_state <= stq_pkg::STQ_EMPTY;  // Drained to store buffer
          end
        endcase
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_addr_hit) begin
        r_paddr <= i_addr_paddr;
        r_size  <= i_addr_size;
      end
      if (w_data_hit) begin
        r_data <= i_data;  // Right-aligned
      end
    end

    assign o_state[s] = r_state;
    assign o_paddr[s] = r_paddr;
    assign o_size[s]  = r_size;
    assign o_data[s]  = r_data;
  end

endmodule

/* logic/stq_fwd.sv */
`timescale 1ns/1ps

module stq_fwd #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  stq_pkg::stq_state_t           i_state [STQ_SIZE],
  input  logic [stq_pkg::PADDR_W-1:0]   i_paddr [STQ_SIZE],
  input  stq_pkg::size_t                i_size  [STQ_SIZE],
  input  logic [stq_pkg::DATA_W-1:0]    i_data  [STQ_SIZE],
  input  logic [IDX_W-1:0]              i_head_index,

  input  logic                          i_fwd_valid,
  input  logic [stq_pkg::PADDR_W-1:0]   i_fwd_paddr,
  input  logic [stq_pkg::DATA_B_W-1:0]  i_fwd_dw,

  output logic                          o_fwd_valid,
  output logic [stq_pkg::DATA_B_W-1:0]  o_fwd_dw,
  output logic [stq_pkg::DATA_W-1:0]    o_fwd_data
);

  localparam int OFF_W = $clog2(stq_pkg::DATA_B_W);

  logic [STQ_SIZE-1:0]           w_hit;
  logic [stq_pkg::DATA_B_W-1:0]  w_strb    [STQ_SIZE];
  logic [stq_pkg::DATA_W-1:0]    w_aligned [STQ_SIZE];

  // Per-entry coverage against the probed doubleword
  for (genvar s = 0; s < STQ_SIZE; s++) begin : g_entry
    assign w_strb[s]    = stq_pkg::base_strb(i_size[s]) << i_paddr[s][OFF_W-1:0];
    assign w_aligned[s] = i_data[s] << {i_paddr[s][OFF_W-1:0], 3'b000};
    assign w_hit[s] = i_fwd_valid &
                      ((i_state[s] == stq_pkg::STQ_READY) |
                       (i_state[s] == stq_pkg::STQ_COMMIT)) &
                      (i_paddr[s][stq_pkg::PADDR_W-1:OFF_W] ==
                       i_fwd_paddr[stq_pkg::PADDR_W-1:OFF_W]);
  end

  // ==========================================================================
  // Youngest match per byte
  // ==========================================================================
  for (genvar b = 0; b < stq_pkg::DATA_B_W; b++) begin : g_byte
    logic [STQ_SIZE-1:0]   w_match;
    logic [2*STQ_SIZE-1:0] w_dbl;
    logic [STQ_SIZE-1:0]   w_rot;   // Bit 0 is the head, oldest
    logic [IDX_W-1:0]      w_sel;
    logic                  w_any;

    for (genvar s = 0; s < STQ_SIZE; s++) begin : g_match
      assign w_match[s] = w_hit[s] & w_strb[s][b] & i_fwd_dw[b];
    end

    assign w_dbl = {w_match, w_match} >> i_head_index;
    assign w_rot = w_dbl[STQ_SIZE-1:0];
    assign w_any = |w_match;

    always_comb begin
      w_sel = i_head_index;
      for (int k = 0; k < STQ_SIZE; k++) begin
        if (w_rot[k]) w_sel = i_head_index + IDX_W'(k);  // Later hit is younger
      end
    end

    assign o_fwd_dw[b]          = w_any;
    assign o_fwd_data[b*8 +: 8] = w_any ? w_aligned[w_sel][b*8 +: 8] : 8'h00;
  end

  assign o_fwd_valid = |o_fwd_dw;

endmodule

/* logic/stq_drain.sv */
`timescale 1ns/1ps

module stq_drain #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  stq_pkg::stq_state_t           i_state [STQ_SIZE],
  input  logic [stq_pkg::PADDR_W-1:0]   i_paddr [STQ_SIZE],
  input  stq_pkg::size_t                i_size  [STQ_SIZE],
  input  logic [stq_pkg::DATA_W-1:0]    i_data  [STQ_SIZE],
  input  logic                          i_stbuf_ready,

  output logic [IDX_W-1:0]              o_head_index,
  output logic [STQ_SIZE-1:0]           o_free_oh,
  output logic                          o_drain_fire,

  output logic                          o_stbuf_valid,
  output logic [stq_pkg::PADDR_W-1:0]   o_stbuf_paddr,
  output logic [stq_pkg::DATA_B_W-1:0]  o_stbuf_strb,
  output logic [stq_pkg::DATA_W-1:0]    o_stbuf_data
);

  localparam int OFF_W = $clog2(stq_pkg::DATA_B_W);

  logic [IDX_W-1:0]            r_head;
  logic [stq_pkg::PADDR_W-1:0] w_paddr;
  logic [OFF_W-1:0]            w_off;
  logic                        w_valid;
  logic                        w_fire;

  assign w_paddr = i_paddr[r_head];
  assign w_off   = w_paddr[OFF_W-1:0];
  assign w_valid = (i_state[r_head] == stq_pkg::STQ_COMMIT);
  assign w_fire  = w_valid & i_stbuf_ready;

  // ==========================================================================
  // Store buffer request from the head entry
  // ==========================================================================
  assign o_stbuf_valid = w_valid;
  assign o_stbuf_paddr = {w_paddr[stq_pkg::PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign o_stbuf_strb  = stq_pkg::base_strb(i_size[r_head]) << w_off;
  assign o_stbuf_data  = i_data[r_head] << {w_off, 3'b000};

  assign o_drain_fire = w_fire;
  assign o_free_oh    = {{(STQ_SIZE-1){1'b0}}, w_fire} << r_head;
  assign o_head_index = r_head;

  // Head holds under back-pressure
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (w_fire) begin
      r_head <= r_head + IDX_W'(1);
    end
  end

endmodule

/* logic/stq_top.sv */
`timescale 1ns/1ps

module stq_top #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_disp_valid,
  output logic [IDX_W-1:0]              o_disp_index,
  output logic                          o_credit_return,

  input  logic                          i_addr_valid,
  input  logic [IDX_W-1:0]              i_addr_index,
  input  logic [stq_pkg::PADDR_W-1:0]   i_addr_paddr,
  input  stq_pkg::size_t                i_addr_size,

  input  logic                          i_data_valid,
  input  logic [IDX_W-1:0]              i_data_index,
  input  logic [stq_pkg::DATA_W-1:0]    i_data,

  input  logic                          i_commit,

  input  logic                          i_fwd_valid,
  input  logic [stq_pkg::PADDR_W-1:0]   i_fwd_paddr,
  input  logic [stq_pkg::DATA_B_W-1:0]  i_fwd_dw,
  output logic                          o_fwd_valid,
  output logic [stq_pkg::DATA_B_W-1:0]  o_fwd_dw,
  output logic [stq_pkg::DATA_W-1:0]    o_fwd_data,

  input  logic                          i_stbuf_ready,
  output logic                          o_stbuf_valid,
  output logic [stq_pkg::PADDR_W-1:0]   o_stbuf_paddr,
  output logic [stq_pkg::DATA_B_W-1:0]  o_stbuf_strb,
  output logic [stq_pkg::DATA_W-1:0]    o_stbuf_data
);

  logic [STQ_SIZE-1:0]          w_alloc_oh;
  logic [STQ_SIZE-1:0]          w_commit_oh;
  logic [STQ_SIZE-1:0]          w_free_oh;
  logic                         w_drain_fire;
  logic [IDX_W-1:0]             w_head_index;
  stq_pkg::stq_state_t          w_state [STQ_SIZE];
  logic [stq_pkg::PADDR_W-1:0]  w_paddr [STQ_SIZE];
  stq_pkg::size_t               w_size  [STQ_SIZE];
  logic [stq_pkg::DATA_W-1:0]   w_data  [STQ_SIZE];

  stq_alloc #(.STQ_SIZE(STQ_SIZE)) u_stq_alloc (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_disp_valid(i_disp_valid), .i_commit(i_commit), .i_drain_fire(w_drain_fire),
    .o_disp_index(o_disp_index), .o_alloc_oh(w_alloc_oh), .o_commit_oh(w_commit_oh),
    .o_credit_return(o_credit_return)
  );

  stq_entries #(.STQ_SIZE(STQ_SIZE)) u_stq_entries (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_alloc_oh(w_alloc_oh), .i_commit_oh(w_commit_oh),
    .i_addr_valid(i_addr_valid), .i_addr_index(i_addr_index),
    .i_addr_paddr(i_addr_paddr), .i_addr_size(i_addr_size),
    .i_data_valid(i_data_valid), .i_data_index(i_data_index), .i_data(i_data),
    .i_free_oh(w_free_oh),
    .o_state(w_state), .o_paddr(w_paddr), .o_size(w_size), .o_data(w_data)
  );

  stq_fwd #(.STQ_SIZE(STQ_SIZE)) u_stq_fwd (
    .i_state(w_state), .i_paddr(w_paddr), .i_size(w_size), .i_data(w_data),
    .i_head_index(w_head_index),
    .i_fwd_valid(i_fwd_valid), .i_fwd_paddr(i_fwd_paddr), .i_fwd_dw(i_fwd_dw),
    .o_fwd_valid(o_fwd_valid), .o_fwd_dw(o_fwd_dw), .o_fwd_data(o_fwd_data)
  );

  stq_drain #(.STQ_SIZE(STQ_SIZE)) u_stq_drain (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_state(w_state), .i_paddr(w_paddr), .i_size(w_size), .i_data(w_data),
    .i_stbuf_ready(i_stbuf_ready),
    .o_head_index(w_head_index), .o_free_oh(w_free_oh), .o_drain_fire(w_drain_fire),
    .o_stbuf_valid(o_stbuf_valid), .o_stbuf_paddr(o_stbuf_paddr),
    .o_stbuf_strb(o_stbuf_strb), .o_stbuf_data(o_stbuf_data)
  );

endmodule

/* verif/stq_checker.sv */
`timescale 1ns/1ps

module stq_checker #(
  parameter int STQ_SIZE = stq_pkg::STQ_SIZE,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic [IDX_W-1:0] i_disp_index,
  input  logic             i_addr_valid,
  input  logic [IDX_W-1:0] i_addr_index,
  input  logic [31:0]      i_addr_paddr,
  input  stq_pkg::size_t   i_addr_size,
  input  logic             i_data_valid,
  input  logic [IDX_W-1:0] i_data_index,
  input  logic [63:0]      i_data,
  input  logic             i_commit,
  input  logic             i_fwd_valid,
  input  logic [31:0]      i_fwd_paddr,
  input  logic [7:0]       i_fwd_dw,
  input  logic             i_fwd_hit,
  input  logic [7:0]       i_fwd_hit_dw,
  input  logic [63:0]      i_fwd_hit_data,
  input  logic             i_stbuf_ready,
  input  logic             i_stbuf_valid,
  input  logic [31:0]      i_stbuf_paddr,
  input  logic [7:0]       i_stbuf_strb,
  input  logic [63:0]      i_stbuf_data,
  input  logic             i_credit_return,
  input  logic [IDX_W-1:0] i_exp_index,   // Expected values from the pattern file
  input  logic [7:0]       i_exp_dw,
  input  logic [63:0]      i_exp_data,
  output logic             o_quiet
);

  // ==========================================================================
  // Reference queue
  // ==========================================================================
  stq_pkg::stq_state_t m_state [STQ_SIZE];
  logic [31:0]         m_paddr [STQ_SIZE];
  stq_pkg::size_t      m_size  [STQ_SIZE];
  logic [63:0]         m_data  [STQ_SIZE];
  logic                m_avld  [STQ_SIZE];
  logic                m_dvld  [STQ_SIZE];
  logic [IDX_W-1:0]    alloc_ptr;
  logic [IDX_W-1:0]    commit_ptr;
  logic [IDX_W-1:0]    head;
  logic                fire_d;
  logic                hold_d;
  logic [103:0]        last_req;
  logic                rst_checked;
  int                  pass_cnt = 0;
  int                  fail_cnt = 0;
  int                  drains = 0;
  int                  credits = 0;

  function automatic logic [7:0] strobe_of(stq_pkg::size_t size, logic [2:0] off);
    logic [7:0] base;
    case (size)
      stq_pkg::SIZE_B: base = 8'h01;
      stq_pkg::SIZE_H: base = 8'h03;
      stq_pkg::SIZE_W: base = 8'h0f;
      default:         base = 8'hff;
    endcase
    return base << off;
  endfunction

  task automatic pass_check(input string msg);
    pass_cnt++;
    $display("PASS %0t: %s", $time, msg);
  endtask

  task automatic flag_error(input string msg);
    fail_cnt++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic print_summary(output int failures);
    if (credits != drains) begin
      flag_error($sformatf("%0d credits returned for %0d drains", credits, drains));
    end
    $display("Checks: %0d passed, %0d failed, %0d drained, %0d credits",
             pass_cnt, fail_cnt, drains, credits);
    failures = fail_cnt;
  endtask

  always @(negedge i_clk) begin
    logic        fire;
    logic        mvalid;
    logic [2:0]  off;
    logic [7:0]  d_strb;
    logic [63:0] d_data;
    logic [7:0]  f_strb;
    logic [63:0] f_al;
    logic [7:0]  f_dw;
    logic [63:0] f_data;
    logic [IDX_W-1:0] e;
    if (!i_reset_n) begin
      for (int s = 0; s < STQ_SIZE; s++) begin
        m_state[s] = stq_pkg::STQ_EMPTY;
      end
      alloc_ptr   = '0;
      commit_ptr  = '0;
      head        = '0;
      fire_d      = 1'b0;
      hold_d      = 1'b0;
      rst_checked = 1'b0;
      o_quiet     = 1'b1;
    end else begin
      if (!rst_checked) begin
        rst_checked = 1'b1;
        if (i_stbuf_valid || i_credit_return || i_fwd_hit) flag_error("outputs high after reset");
        else pass_check("reset state");
      end

      // Drain request from the head
      mvalid = (m_state[head] == stq_pkg::STQ_COMMIT);
      off    = m_paddr[head][2:0];
      d_strb = strobe_of(m_size[head], off);
      d_data = m_data[head] << {off, 3'b000};
      fire   = mvalid & i_stbuf_ready;
      if (i_stbuf_valid !== mvalid) begin
        flag_error($sformatf("store buffer valid %b, expected %b", i_stbuf_valid, mvalid));
      end else if (mvalid && (i_stbuf_paddr !== {m_paddr[head][31:3], 3'b000} ||
                              i_stbuf_strb !== d_strb || i_stbuf_data !== d_data)) begin
        flag_error($sformatf("entry %0d request %h/%h/%h, expected strb %h data %h",
                             head, i_stbuf_paddr, i_stbuf_strb, i_stbuf_data, d_strb, d_data));
      end else if (fire) begin
        pass_check($sformatf("drain of entry %0d", head));
      end
      if (hold_d && {i_stbuf_paddr, i_stbuf_strb, i_stbuf_data} !== last_req) begin
        flag_error("request changed under back-pressure");
      end
      hold_d   = i_stbuf_valid & !i_stbuf_ready;
      last_req = {i_stbuf_paddr, i_stbuf_strb, i_stbuf_data};
      if (i_credit_return !== fire_d) flag_error("credit pulse out of step with drains");
      if (i_credit_return) credits++;
      fire_d = fire;

      if (i_disp_valid) begin
        if (i_disp_index !== alloc_ptr || i_disp_index !== i_exp_index)
          flag_error($sformatf("dispatch index %0d, expected %0d", i_disp_index, alloc_ptr));
        else pass_check($sformatf("dispatch index %0d", i_disp_index));
      end

      // Youngest covering store per byte, walking from the head
      f_dw   = '0;
      f_data = '0;
      if (i_fwd_valid) begin
        for (int k = 0; k < STQ_SIZE; k++) begin
          e = head + IDX_W'(k);
          if ((m_state[e] == stq_pkg::STQ_READY || m_state[e] == stq_pkg::STQ_COMMIT) &&
              m_paddr[e][31:3] == i_fwd_paddr[31:3]) begin
            f_strb = strobe_of(m_size[e], m_paddr[e][2:0]) & i_fwd_dw;
            f_al   = m_data[e] << {m_paddr[e][2:0], 3'b000};
            for (int b = 0; b < 8; b++) begin
              if (f_strb[b]) begin
                f_dw[b]         = 1'b1;
                f_data[b*8 +: 8] = f_al[b*8 +: 8];
              end
            end
          end
        end
      end
      if (i_fwd_hit !== (|f_dw) || i_fwd_hit_dw !== f_dw || i_fwd_hit_data !== f_data) begin
        flag_error($sformatf("forward %h/%h, expected %h/%h",
                             i_fwd_hit_dw, i_fwd_hit_data, f_dw, f_data));
      end else if (i_fwd_valid && (f_dw !== i_exp_dw || f_data !== i_exp_data)) begin
        flag_error($sformatf("forward %h/%h, pattern expects %h/%h",
                             f_dw, f_data, i_exp_dw, i_exp_data));
      end else if (i_fwd_valid) begin
        pass_check($sformatf("forward probe at %h", i_fwd_paddr));
      end

      // Advance the model to the next edge
      if (i_commit) begin
        if (m_state[commit_ptr] == stq_pkg::STQ_READY) m_state[commit_ptr] = stq_pkg::STQ_COMMIT;
        else flag_error($sformatf("commit of entry %0d which is not ready", commit_ptr));
        commit_ptr++;
      end
      if (i_addr_valid) begin
        m_paddr[i_addr_index] = i_addr_paddr;
        m_size[i_addr_index]  = i_addr_size;
        if (m_state[i_addr_index] == stq_pkg::STQ_WAIT) m_avld[i_addr_index] = 1'b1;
      end
      if (i_data_valid) begin
        m_data[i_data_index] = i_data;
        if (m_state[i_data_index] == stq_pkg::STQ_WAIT) m_dvld[i_data_index] = 1'b1;
      end
      for (int s = 0; s < STQ_SIZE; s++) begin
        if (m_state[s] == stq_pkg::STQ_WAIT && m_avld[s] && m_dvld[s])
          m_state[s] = stq_pkg::STQ_READY;
      end
      if (i_disp_valid) begin
        if (m_state[alloc_ptr] != stq_pkg::STQ_EMPTY) flag_error("dispatch with no free entry");
        m_state[alloc_ptr] = stq_pkg::STQ_WAIT;
        m_avld[alloc_ptr]  = 1'b0;
        m_dvld[alloc_ptr]  = 1'b0;
        alloc_ptr++;
      end
      if (fire) begin
        m_state[head] = stq_pkg::STQ_EMPTY;
        head++;
        drains++;
      end
      o_quiet = !fire_d;
      for (int s = 0; s < STQ_SIZE; s++) begin
        if (m_state[s] != stq_pkg::STQ_EMPTY) o_quiet = 1'b0;
      end
    end
  end

endmodule

/* verif/stq_tb.sv */
`timescale 1ns/1ps

module stq_tb;

  localparam string PATTERN_FILE   = "verif/stq_patterns.txt";
  localparam int    TIMEOUT_MARGIN = 200;
  localparam int    SWEEP_STORES   = 21;  // 8 + 7 + 5 + 1 offsets over the four sizes
  localparam int    IDX_W          = $clog2(stq_pkg::STQ_SIZE);

  typedef enum {DISP, ADDR, DATA, BOTH, COMMIT, FWD, STALL, IDLE} op_t;

  logic             clk;
  logic             reset_n;
  logic             disp_valid;
  logic [IDX_W-1:0] disp_index;
  logic             credit_return;
  logic             addr_valid;
  logic [IDX_W-1:0] addr_index;
  logic [31:0]      addr_paddr;
  stq_pkg::size_t   addr_size;
  logic             data_valid;
  logic [IDX_W-1:0] data_index;
  logic [63:0]      data;
  logic             commit;
  logic             fwd_valid;
  logic [31:0]      fwd_paddr;
  logic [7:0]       fwd_dw;
  logic             fwd_hit;
  logic [7:0]       fwd_hit_dw;
  logic [63:0]      fwd_hit_data;
  logic             stbuf_ready;
  logic             stbuf_valid;
  logic [31:0]      stbuf_paddr;
  logic [7:0]       stbuf_strb;
  logic [63:0]      stbuf_data;
  logic [IDX_W-1:0] exp_index;
  logic [7:0]       exp_dw;
  logic [63:0]      exp_data;
  logic             quiet;

  op_t         ops [$];
  logic [63:0] fa [$];
  logic [63:0] fb [$];
  logic [63:0] fc [$];
  logic [63:0] fd [$];
  integer      seed = 32'h1fe0;
  int          stall_left = 0;
  int          disp_count = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          tb_errors = 0;

  stq_top u_stq_top (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_disp_valid(disp_valid), .o_disp_index(disp_index), .o_credit_return(credit_return),
    .i_addr_valid(addr_valid), .i_addr_index(addr_index),
    .i_addr_paddr(addr_paddr), .i_addr_size(addr_size),
    .i_data_valid(data_valid), .i_data_index(data_index), .i_data(data),
    .i_commit(commit),
    .i_fwd_valid(fwd_valid), .i_fwd_paddr(fwd_paddr), .i_fwd_dw(fwd_dw),
    .o_fwd_valid(fwd_hit), .o_fwd_dw(fwd_hit_dw), .o_fwd_data(fwd_hit_data),
    .i_stbuf_ready(stbuf_ready), .o_stbuf_valid(stbuf_valid), .o_stbuf_paddr(stbuf_paddr),
    .o_stbuf_strb(stbuf_strb), .o_stbuf_data(stbuf_data)
  );

  stq_checker u_checker (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_disp_valid(disp_valid), .i_disp_index(disp_index),
    .i_addr_valid(addr_valid), .i_addr_index(addr_index),
    .i_addr_paddr(addr_paddr), .i_addr_size(addr_size),
    .i_data_valid(data_valid), .i_data_index(data_index), .i_data(data),
    .i_commit(commit),
    .i_fwd_valid(fwd_valid), .i_fwd_paddr(fwd_paddr), .i_fwd_dw(fwd_dw),
    .i_fwd_hit(fwd_hit), .i_fwd_hit_dw(fwd_hit_dw), .i_fwd_hit_data(fwd_hit_data),
    .i_stbuf_ready(stbuf_ready), .i_stbuf_valid(stbuf_valid), .i_stbuf_paddr(stbuf_paddr),
    .i_stbuf_strb(stbuf_strb), .i_stbuf_data(stbuf_data), .i_credit_return(credit_return),
    .i_exp_index(exp_index), .i_exp_dw(exp_dw), .i_exp_data(exp_data),
    .o_quiet(quiet)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // Timeout
  // ==========================================================================
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // Drives one cycle of DUT inputs on the rising edge
  task automatic drive_cycle(input op_t op, input logic [63:0] a, b, c, d);
    @(posedge clk);
    disp_valid <= (op == DISP);
    addr_valid <= (op == ADDR) || (op == BOTH);
    data_valid <= (op == DATA) || (op == BOTH);
    commit     <= (op == COMMIT);
    fwd_valid  <= (op == FWD);
    if (op == DISP) begin
      exp_index <= a[IDX_W-1:0];
      disp_count++;
    end
    if (op == ADDR || op == BOTH) begin
      addr_index <= a[IDX_W-1:0];
      addr_paddr <= b[31:0];
      addr_size  <= stq_pkg::size_t'(c[1:0]);
    end
    if (op == DATA || op == BOTH) begin
      data_index <= a[IDX_W-1:0];
      data       <= d;
    end
    if (op == FWD) begin
      fwd_paddr <= a[31:0];
      fwd_dw    <= b[7:0];
      exp_dw    <= c[7:0];
      exp_data  <= d;
    end
    if (stall_left > 0) begin
      stbuf_ready <= 1'b0;  // Back-pressure window
      stall_left  = stall_left - 1;
    end else begin
      stbuf_ready <= (({$random(seed)} % 3) != 0);
    end
  endtask

  // Every store size at every offset that fits a doubleword, one store in flight
  task automatic sweep_sizes();
    logic [63:0] idx;
    logic [63:0] paddr;
    logic [63:0] mask;
    logic [63:0] wdata;
    int          bytes;
    for (int sz = 0; sz < 4; sz++) begin
      bytes = 1 << sz;
      mask  = (bytes == 8) ? '1 : ((64'd1 << (8 * bytes)) - 64'd1);
      for (int off = 0; off + bytes <= 8; off++) begin
        idx   = 64'(disp_count % stq_pkg::STQ_SIZE);  // In-order wrapping index
        paddr = 64'h4000 + 64'(sz * 64 + off);
        wdata = {$random(seed), $random(seed)} & mask;
        drive_cycle(DISP, idx, '0, '0, '0);
        drive_cycle(BOTH, idx, paddr, 64'(sz), wdata);
        drive_cycle(COMMIT, '0, '0, '0, '0);
        do begin
          drive_cycle(IDLE, '0, '0, '0, '0);
          @(negedge clk);
        end while (!credit_return);
      end
    end
  endtask

  initial begin
    int          fh;
    int          n;
    string       tok;
    string       rest;
    logic [63:0] a, b, c, d;
    int          failures;
    reset_n = 1'b0;
    {disp_valid, addr_valid, data_valid, commit, fwd_valid, stbuf_ready} = '0;
    {addr_index, addr_paddr, data_index, data, fwd_paddr, fwd_dw} = '0;
    addr_size = stq_pkg::SIZE_B;
    {exp_index, exp_dw, exp_data} = '0;

    fh = $fopen(PATTERN_FILE, "r");
    if (fh == 0) begin
      $display("Could not open the pattern file %s", PATTERN_FILE);
      tb_errors++;
    end else begin
      while (!$feof(fh)) begin
        n = $fscanf(fh, "%s", tok);
        if (n != 1) break;
        if (tok.substr(0, 0) == "#") begin
          n = $fgets(rest, fh);  // Comment line
        end else begin
          n = $fscanf(fh, "%h %h %h %h", a, b, c, d);
          fa.push_back(a);
          fb.push_back(b);
          fc.push_back(c);
          fd.push_back(d);
          case (tok)
            "DISP":   ops.push_back(DISP);
            "ADDR":   ops.push_back(ADDR);
            "DATA":   ops.push_back(DATA);
            "BOTH":   ops.push_back(BOTH);
            "COMMIT": ops.push_back(COMMIT);
            "FWD":    ops.push_back(FWD);
            "STALL":  ops.push_back(STALL);
            "IDLE":   ops.push_back(IDLE);
            default: begin
              $display("Unknown opcode %s in the pattern file", tok);
              tb_errors++;
              ops.push_back(IDLE);
            end
          endcase
        end
      end
      $fclose(fh);
    end
    cycle_limit = 4 * (ops.size() + 3 * SWEEP_STORES) + TIMEOUT_MARGIN;

    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    foreach (ops[i]) begin
      if (ops[i] == IDLE) begin
        repeat (fa[i]) drive_cycle(IDLE, '0, '0, '0, '0);
      end else begin
        if (ops[i] == STALL) stall_left = int'(fa[i]);
        drive_cycle(ops[i], fa[i], fb[i], fc[i], fd[i]);
      end
    end
    // Let committed stores drain
    do begin
      drive_cycle(IDLE, '0, '0, '0, '0);
    end while (!quiet);
    sweep_sizes();
    @(posedge clk);

    u_checker.print_summary(failures);
    if (failures == 0 && tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* stq_top.f */
logic/stq_pkg.sv
logic/stq_alloc.sv
logic/stq_entries.sv
logic/stq_fwd.sv
logic/stq_drain.sv
logic/stq_top.sv
verif/stq_checker.sv
verif/stq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --top-module stq_tb -f stq_top.f -o stq_sim > sim.log 2>&1 \
  && ./obj_dir/stq_sim >> sim.log 2>&1 \
  || { echo "Build or simulation error, see sim.log"; exit 1; }

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0

/* verif/stq_patterns.txt */
# op  a  b  c  d (hex) | DISP exp_idx | ADDR idx paddr size | DATA idx - - data | BOTH idx paddr size data
# COMMIT | FWD paddr mask exp_dw exp_data | STALL cycles_low | IDLE cycles ; size 0=B 1=H 2=W 3=DW
DISP   0 0 0 0
DISP   1 0 0 0
DISP   2 0 0 0
DISP   3 0 0 0
ADDR   0 1000 3 0
DATA   0 0 0 1122334455667788
BOTH   1 1002 1 aabb
ADDR   2 1005 0 0
DATA   3 0 0 cc
FWD    1000 ff ff 11223344aabb7788
DATA   2 0 0 ee
FWD    1000 24 24 0000ee0000bb0000
STALL  6 0 0 0
COMMIT 0 0 0 0
COMMIT 0 0 0 0
FWD    1000 ff ff 1122ee44aabb7788
ADDR   3 1010 0 0
FWD    1010 01 01 00000000000000cc
IDLE   10 0 0 0
FWD    1000 ff 20 0000ee0000000000
COMMIT 0 0 0 0
COMMIT 0 0 0 0
DISP   4 0 0 0
BOTH   4 2007 0 5a
DISP   5 0 0 0
BOTH   5 2004 2 01020304
FWD    2000 c0 c0 0102000000000000
COMMIT 0 0 0 0
COMMIT 0 0 0 0
DISP   6 0 0 0
DISP   7 0 0 0
DISP   0 0 0 0
BOTH   6 3000 3 0123456789abcdef
BOTH   7 3006 1 beef
BOTH   0 3001 0 77
FWD    3000 ff ff beef456789ab77ef
COMMIT 0 0 0 0
COMMIT 0 0 0 0
COMMIT 0 0 0 0
IDLE   20 0 0 0
